// ==== imuldiv_div.f ====
+incdir+.
imuldiv_msg_pkg.sv
imuldiv_div_ctrl_pkg.sv
imuldiv_msg_queue.sv
imuldiv_div_dpath.sv
imuldiv_div_ctrl.sv
imuldiv_div_iterative.sv
imuldiv_div_unit.sv
imuldiv_div_tb.sv

// ==== imuldiv_div_ctrl.sv ====
//----------------------------------------------------------------------------
// divider control FSM: IDLE/CALC/DONE sequencing, datapath enables
// and mux selects, request and response handshakes
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_div_ctrl (
  input  logic                              clk,
  input  logic                              reset,

  input  logic                              req_val,
  output logic                              req_rdy,
  output logic                              resp_val,
  input  logic                              resp_rdy,

  input  imuldiv_div_ctrl_pkg::div_status_t status,
  output imuldiv_div_ctrl_pkg::div_ctrl_t   ctrl
);

  import imuldiv_div_ctrl_pkg::*;

  div_state_t state;
  div_state_t state_next;
  // set once the signed result has been registered in ST_DONE
  logic       res_done;
  logic       req_go;
  logic       resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  //--------------------------------------------------------------------------
  // state register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      res_done <= 1'b0;
    end else begin
      state    <= state_next;
      // first DONE cycle writes the result, later ones present it
      res_done <= (state == ST_DONE) && !resp_go;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (req_go) state_next = ST_CALC;
      // last quotient bit is produced in the zero-count cycle
      ST_CALC: if (status.counter_is_zero) state_next = ST_DONE;
      ST_DONE: if (resp_go) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  //--------------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------------

  always_comb begin
    req_rdy           = 1'b0;
    resp_val          = 1'b0;
    ctrl              = '0;
    ctrl.a_mux_sel    = A_MUX_LOAD;
    ctrl.sub_mux_sel  = SUB_MUX_KEEP;
    ctrl.cntr_mux_sel = CNTR_MUX_RELOAD;
    case (state)
      ST_IDLE: begin
        req_rdy      = 1'b1;
        // load operands, signs and counter on acceptance
        ctrl.a_en    = req_go;
        ctrl.b_en    = req_go;
        ctrl.sign_en = req_go;
      end
      ST_CALC: begin
        ctrl.a_en         = 1'b1;
        ctrl.a_mux_sel    = A_MUX_ITER;
        ctrl.cntr_mux_sel = CNTR_MUX_DEC;
        // borrow from the datapath decides restore
        ctrl.sub_mux_sel  = status.sub_neg ? SUB_MUX_RESTORE : SUB_MUX_KEEP;
      end
      ST_DONE: begin
        ctrl.res_sign_sel = !res_done;
        resp_val          = res_done;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// ==== imuldiv_div_ctrl_pkg.sv ====
//----------------------------------------------------------------------------
// divider FSM state encoding, datapath mux select codes and the
// control and status structs passed between FSM and datapath
//----------------------------------------------------------------------------

package imuldiv_div_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_t;

  // mux select codes
  localparam logic A_MUX_LOAD      = 1'b0;
  localparam logic A_MUX_ITER      = 1'b1;
  localparam logic SUB_MUX_KEEP    = 1'b0;
  localparam logic SUB_MUX_RESTORE = 1'b1;
  localparam logic CNTR_MUX_RELOAD = 1'b0;
  localparam logic CNTR_MUX_DEC    = 1'b1;

  // FSM to datapath
  typedef struct packed {
    logic a_en;
    logic b_en;
    logic a_mux_sel;
    logic sub_mux_sel;
    logic cntr_mux_sel;
    logic sign_en;
    logic res_sign_sel;
  } div_ctrl_t;

  // datapath to FSM
  typedef struct packed {
    logic sub_neg;
    logic counter_is_zero;
  } div_status_t;

endpackage

// ==== imuldiv_div_dpath.sv ====
//----------------------------------------------------------------------------
// divider datapath: operand unsigning, restoring shift/subtract registers,
// iteration counter and registered result sign fix-up
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`include "imuldiv_settings.svh"

module imuldiv_div_dpath (
  input  logic                              clk,
  input  logic                              reset,
  input  imuldiv_msg_pkg::div_req_msg_t     req_msg,
  input  imuldiv_div_ctrl_pkg::div_ctrl_t   ctrl,
  output imuldiv_div_ctrl_pkg::div_status_t status,
  output imuldiv_msg_pkg::div_resp_msg_t    resp_msg
);

  import imuldiv_msg_pkg::*;
  import imuldiv_div_ctrl_pkg::*;

  localparam int W     = `IMULDIV_DATA_W;
  localparam int CNT_W = $clog2(W);

  // a_reg: remainder in [2W-1:W], quotient bits shift in at [0]
  // b_reg: divisor magnitude aligned to the upper half
  logic [2*W:0]     a_reg;
  logic [2*W:0]     b_reg;
  logic [CNT_W-1:0] counter;

  // captured at load for the output fix-up
  logic is_signed;
  logic a_neg;
  logic b_neg;

  logic         req_signed;
  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;
  logic [2*W:0] a_init;
  logic [2*W:0] b_init;
  logic [2*W:0] a_shift;
  logic [2*W:0] sub_out;
  logic [2*W:0] a_keep;
  logic [2*W:0] a_iter;
  logic         quot_neg;
  logic         rem_neg;
  logic [W-1:0] quot_mag;
  logic [W-1:0] rem_mag;

  //--------------------------------------------------------------------------
  // operand unsigning
  //--------------------------------------------------------------------------

  assign req_signed = (req_msg.fn == DIV_FN_SIGNED);

  // negative operands only matter for the signed function
  assign a_mag = (req_signed && req_msg.a[W-1]) ? -req_msg.a : req_msg.a;
  assign b_mag = (req_signed && req_msg.b[W-1]) ? -req_msg.b : req_msg.b;

  assign a_init = {{(W+1){1'b0}}, a_mag};
  assign b_init = {1'b0, b_mag, {W{1'b0}}};

  //--------------------------------------------------------------------------
  // shift and subtract
  //--------------------------------------------------------------------------

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;

  // difference fits, keep it and set the quotient bit
  assign a_keep = {sub_out[2*W:1], 1'b1};
  // on restore the shifted value already carries a zero quotient bit
  assign a_iter = (ctrl.sub_mux_sel == SUB_MUX_RESTORE) ? a_shift : a_keep;

  // top bit of the 65-bit difference is the borrow
  assign status = '{sub_neg: sub_out[2*W], counter_is_zero: (counter == '0)};

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_reg <= (ctrl.a_mux_sel == A_MUX_ITER) ? a_iter : a_init;
    end
    if (ctrl.b_en) begin
      b_reg <= b_init;
    end
  end

  // iteration counter, W-1 down to 0, stepped with a_reg
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (ctrl.a_en) begin
      counter <= (ctrl.cntr_mux_sel == CNTR_MUX_DEC) ? counter - CNT_W'(1)
                                                     : CNT_W'(W - 1);
    end
  end

  // sign capture
  always_ff @(posedge clk) begin
    if (reset) begin
      is_signed <= 1'b0;
      a_neg     <= 1'b0;
      b_neg     <= 1'b0;
    end else if (ctrl.sign_en) begin
      is_signed <= req_signed;
      a_neg     <= req_msg.a[W-1];
      b_neg     <= req_msg.b[W-1];
    end
  end

  //--------------------------------------------------------------------------
  // result sign fix-up
  //--------------------------------------------------------------------------

  // quotient sign is the xor of operand signs, remainder follows dividend
  assign quot_neg = is_signed && (a_neg ^ b_neg);
  assign rem_neg  = is_signed && a_neg;

  assign quot_mag = a_reg[W-1:0];
  assign rem_mag  = a_reg[2*W-1:W];

  // response register, loaded once at the start of ST_DONE
  always_ff @(posedge clk) begin
    if (ctrl.res_sign_sel) begin
      resp_msg.rem  <= rem_neg  ? -rem_mag  : rem_mag;
      resp_msg.quot <= quot_neg ? -quot_mag : quot_mag;
    end
  end

endmodule

// ==== imuldiv_div_iterative.sv ====
//----------------------------------------------------------------------------
// iterative divider, control FSM and datapath behind one val/rdy port pair
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_div_iterative (
  input  logic                           clk,
  input  logic                           reset,

  input  imuldiv_msg_pkg::div_req_msg_t  req_msg,
  input  logic                           req_val,
  output logic                           req_rdy,

  output imuldiv_msg_pkg::div_resp_msg_t resp_msg,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  import imuldiv_div_ctrl_pkg::*;

  // control out, status back
  div_ctrl_t   ctrl;
  div_status_t status;

  imuldiv_div_ctrl div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .status   (status),
    .ctrl     (ctrl)
  );

  // request message is sampled straight off the port on load
  imuldiv_div_dpath div_dpath (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .ctrl     (ctrl),
    .status   (status),
    .resp_msg (resp_msg)
  );

endmodule

// ==== imuldiv_div_tb.sv ====
//----------------------------------------------------------------------------
// self-checking testbench for the divide unit
// stimulus table, LCG random phase, reference model, back-pressure driver
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`include "imuldiv_settings.svh"

module imuldiv_div_tb;

  import imuldiv_msg_pkg::*;

  localparam int          W      = `IMULDIV_DATA_W;
  localparam logic [31:0] SEED   = 32'h96e4b357;
  localparam int          N_RAND = 200;

  // one table row with its expected results
  typedef struct packed {
    div_fn_t      fn;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] rem;
    logic [W-1:0] quot;
  } vec_t;

  logic          clk;
  logic          reset;
  div_req_msg_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  div_resp_msg_t resp_msg;
  logic          resp_val;
  logic          resp_rdy;

  vec_t          vec_table [$];
  // expected responses in issue order
  div_resp_msg_t exp_q [$];
  div_resp_msg_t exp_resp;
  logic [31:0]   vec_state;
  logic [31:0]   bp_state;
  logic [W-1:0]  rand_a;
  logic [W-1:0]  rand_b;
  logic [4:0]    rand_shift;
  div_fn_t       rand_fn;
  int            total_vecs;
  int            timeout_limit;
  int            cycle_count;
  logic          req_stall_seen;

  imuldiv_div_unit DUT (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #10 clk = ~clk;

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // behavioral divide on magnitudes with the sign rules applied after
  function automatic div_resp_msg_t expected_result(input div_fn_t fn,
                                                    input logic [W-1:0] a,
                                                    input logic [W-1:0] b);
    logic         sgn;
    logic [W-1:0] a_abs;
    logic [W-1:0] b_abs;
    logic [W-1:0] q;
    logic [W-1:0] r;
    sgn   = (fn == DIV_FN_SIGNED);
    a_abs = (sgn && a[W-1]) ? -a : a;
    b_abs = (sgn && b[W-1]) ? -b : b;
    q     = a_abs / b_abs;
    r     = a_abs % b_abs;
    if (sgn && (a[W-1] ^ b[W-1])) begin
      q = -q;
    end
    if (sgn && a[W-1]) begin
      r = -r;
    end
    return '{rem: r, quot: q};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic add_row(input div_fn_t fn, input logic [W-1:0] a, input logic [W-1:0] b,
                         input logic [W-1:0] rem, input logic [W-1:0] quot);
    vec_table.push_back('{fn: fn, a: a, b: b, rem: rem, quot: quot});
  endtask

  task automatic fill_table();
    // unsigned
    add_row(DIV_FN_UNSIGNED, 32'd100,       32'd7,         32'd2,         32'd14);
    add_row(DIV_FN_UNSIGNED, 32'hffffffff,  32'd1,         32'd0,         32'hffffffff);
    add_row(DIV_FN_UNSIGNED, 32'd12345,     32'd12345,     32'd0,         32'd1);
    add_row(DIV_FN_UNSIGNED, 32'd5,         32'd9,         32'd5,         32'd0);
    add_row(DIV_FN_UNSIGNED, 32'h80000000,  32'h10,        32'd0,         32'h08000000);
    add_row(DIV_FN_UNSIGNED, 32'hffffffff,  32'hfffffffe,  32'd1,         32'd1);
    add_row(DIV_FN_UNSIGNED, 32'd0,         32'd5,         32'd0,         32'd0);
    // signed rows cover all four sign combinations
    add_row(DIV_FN_SIGNED,   32'd100,       32'd7,         32'd2,         32'd14);
    add_row(DIV_FN_SIGNED,   32'hffffff9c,  32'd7,         32'hfffffffe,  32'hfffffff2);
    add_row(DIV_FN_SIGNED,   32'd100,       32'hfffffff9,  32'd2,         32'hfffffff2);
    add_row(DIV_FN_SIGNED,   32'hffffff9c,  32'hfffffff9,  32'hfffffffe,  32'd14);
    add_row(DIV_FN_SIGNED,   32'hfffffff9,  32'd2,         32'hffffffff,  32'hfffffffd);
    // most negative dividend
    add_row(DIV_FN_SIGNED,   32'h80000000,  32'hffffffff,  32'd0,         32'h80000000);
    add_row(DIV_FN_SIGNED,   32'h80000000,  32'd2,         32'd0,         32'hc0000000);
    // divide by zero leaves the dividend as remainder
    add_row(DIV_FN_UNSIGNED, 32'd1234,      32'd0,         32'd1234,      32'hffffffff);
    add_row(DIV_FN_SIGNED,   32'd1234,      32'd0,         32'd1234,      32'hffffffff);
    add_row(DIV_FN_SIGNED,   32'hfffffb2e,  32'd0,         32'hfffffb2e,  32'd1);
  endtask

  // holds the request until the request queue takes it
  task automatic send_request(input div_fn_t req_fn, input logic [W-1:0] a,
                              input logic [W-1:0] b, input div_resp_msg_t exp);
    req_msg = '{fn: req_fn, a: a, b: b};
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    exp_q.push_back(exp);
    #1;
  endtask

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    req_msg        = '0;
    req_val        = 1'b0;
    resp_rdy       = 1'b0;
    vec_state      = SEED;
    bp_state       = ~SEED;
    cycle_count    = 0;
    req_stall_seen = 1'b0;
    fill_table();
    total_vecs    = vec_table.size() + N_RAND;
    timeout_limit = total_vecs * 40 * 4 + 200;

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    // idle state right after reset
    check_value("req_rdy", 64'(req_rdy), 64'h1);
    check_value("resp_val", 64'(resp_val), 64'h0);
    #1;

    foreach (vec_table[i]) begin
      send_request(vec_table[i].fn, vec_table[i].a, vec_table[i].b,
                   '{rem: vec_table[i].rem, quot: vec_table[i].quot});
    end

    // random phase where shifted divisors give a spread of quotient sizes
    for (int i = 0; i < N_RAND; i++) begin
      vec_state  = lcg_next(vec_state);
      rand_a     = vec_state;
      vec_state  = lcg_next(vec_state);
      rand_fn    = vec_state[31] ? DIV_FN_SIGNED : DIV_FN_UNSIGNED;
      rand_shift = vec_state[30:26];
      vec_state  = lcg_next(vec_state);
      rand_b     = vec_state >> rand_shift;
      if (rand_b == '0) begin
        rand_b = 32'd1;
      end
      send_request(rand_fn, rand_a, rand_b, expected_result(rand_fn, rand_a, rand_b));
    end
    req_val = 1'b0;

    // a lost response keeps this loop waiting until the timeout
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // a quiet tail catches duplicated responses
    repeat (50) @(posedge clk);

    if (resp_val !== 1'b1 && req_stall_seen) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("final check failed: resp_val %0b, stall seen %0b",
               resp_val, req_stall_seen);
      $display("TEST FAIL");
      $fatal(1, "final check failed");
    end
  end

  //--------------------------------------------------------------------------
  // back-pressure, response monitor, timeout
  //--------------------------------------------------------------------------

  // long stall windows fill both queues and hold the divider in ST_DONE
  always @(posedge clk) begin
    #1;
    bp_state = lcg_next(bp_state);
    if ((cycle_count % 600) >= 400) begin
      resp_rdy = 1'b0;
    end else begin
      resp_rdy = (bp_state[31:30] != 2'b00);
    end
  end

  // sampled at the edge before the DUT updates
  always @(posedge clk) begin
    if (!reset && !req_rdy) begin
      req_stall_seen = 1'b1;
    end
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        $display("TEST FAIL");
        $fatal(1, "unexpected response");
      end else begin
        exp_resp = exp_q.pop_front();
        check_value("resp_msg.rem", 64'(resp_msg.rem), 64'(exp_resp.rem));
        check_value("resp_msg.quot", 64'(resp_msg.quot), 64'(exp_resp.quot));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("run did not finish within %0d cycles", timeout_limit);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== imuldiv_div_unit.sv ====
//----------------------------------------------------------------------------
// divide unit top: request queue, iterative divider, response queue
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`include "imuldiv_settings.svh"

module imuldiv_div_unit (
  input  logic                           clk,
  input  logic                           reset,

  input  imuldiv_msg_pkg::div_req_msg_t  req_msg,
  input  logic                           req_val,
  output logic                           req_rdy,

  output imuldiv_msg_pkg::div_resp_msg_t resp_msg,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  import imuldiv_msg_pkg::*;

  // request queue to divider
  div_req_msg_t  div_req_msg;
  logic          div_req_val;
  logic          div_req_rdy;

  // divider to response queue
  div_resp_msg_t div_resp_msg;
  logic          div_resp_val;
  logic          div_resp_rdy;

  imuldiv_msg_queue #(
    .msg_t (div_req_msg_t),
    .DEPTH (`IMULDIV_QUEUE_DEPTH)
  ) req_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (req_msg),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .deq_msg (div_req_msg),
    .deq_val (div_req_val),
    .deq_rdy (div_req_rdy)
  );

  imuldiv_div_iterative divider (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (div_req_msg),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_msg (div_resp_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  // absorbs back-pressure from the consumer
  imuldiv_msg_queue #(
    .msg_t (div_resp_msg_t),
    .DEPTH (`IMULDIV_QUEUE_DEPTH)
  ) resp_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (div_resp_msg),
    .enq_val (div_resp_val),
    .enq_rdy (div_resp_rdy),
    .deq_msg (resp_msg),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy)
  );

endmodule

// ==== imuldiv_msg_pkg.sv ====
//----------------------------------------------------------------------------
// request and response message types of the divide unit
// function-code enum, packed request and packed response
//----------------------------------------------------------------------------

`include "imuldiv_settings.svh"

package imuldiv_msg_pkg;

  //--------------------------------------------------------------------------
  // function codes
  //--------------------------------------------------------------------------

  // one bit selects how the operands are interpreted
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_t;

  //--------------------------------------------------------------------------
  // messages
  //--------------------------------------------------------------------------

  // request: fn in the top bit, then dividend, then divisor
  typedef struct packed {
    div_fn_t                     fn;
    logic [`IMULDIV_DATA_W-1:0]  a;
    logic [`IMULDIV_DATA_W-1:0]  b;
  } div_req_msg_t;

  // response: remainder in the upper half, quotient in the lower half
  typedef struct packed {
    logic [`IMULDIV_DATA_W-1:0]  rem;
    logic [`IMULDIV_DATA_W-1:0]  quot;
  } div_resp_msg_t;

endpackage

// ==== imuldiv_msg_queue.sv ====
//----------------------------------------------------------------------------
// generic val/rdy message FIFO, circular buffer of a packed type
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_msg_queue #(
  parameter type msg_t = logic [7:0],
  parameter int  DEPTH = 2
) (
  input  logic clk,
  input  logic reset,

  input  msg_t enq_msg,
  input  logic enq_val,
  output logic enq_rdy,

  output msg_t deq_msg,
  output logic deq_val,
  input  logic deq_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  msg_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             enq_go;
  logic             deq_go;

  // pointer advance with wrap at DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  // full and empty come straight from the occupancy count
  assign enq_rdy = (count != CNT_W'(DEPTH));
  assign deq_val = (count != '0);
  assign deq_msg = mem[rd_ptr];

  assign enq_go = enq_val && enq_rdy;
  assign deq_go = deq_val && deq_rdy;

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_go) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (deq_go) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // simultaneous enq and deq leaves the count alone
      case ({enq_go, deq_go})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // storage, written on enqueue only
  always_ff @(posedge clk) begin
    if (enq_go) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

endmodule

// ==== imuldiv_settings.svh ====
//----------------------------------------------------------------------------
// global sizing macros for the integer divide unit
// operand width and default message queue depth
//----------------------------------------------------------------------------

`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// width of each operand, quotient and remainder
`define IMULDIV_DATA_W 32

// entries per val/rdy message queue
// two entries keep one message moving while the next one waits
`define IMULDIV_QUEUE_DEPTH 2

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the divide unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -sv -j 0 \
  --top-module imuldiv_div_tb \
  -f imuldiv_div.f \
  -o Vimuldiv_div_tb

sim_out=$(./obj_dir/Vimuldiv_div_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi
